// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_cache_tile
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert -Wno-fatal --top-module $(TOP) --Mdir $(BUILD_DIR)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run into $(LOG), fail on a failed run"
	@echo "  clean  remove build outputs and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "sim failed" $(LOG) || ! grep -q "sim passed" $(LOG); then \
		echo "test FAILED, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: all.f
design/cache_pkg.sv
design/dma_pkg.sv
design/link_to_cache.sv
design/cache_dm.sv
design/cache_to_mem.sv
design/cache_tile_top.sv
verif/mem_model.sv
verif/tb_cache_tile.sv

// File: design/cache_dm.sv
/*
 * cache_dm
 * Direct-mapped write-back data cache. One operation in flight; a miss
 * writes back a dirty victim block, fetches the new block over DMA and
 * replays the access. Hits answer two cycles after acceptance.
 */
module cache_dm #(
  parameter addr_width_p = 12
  ,parameter data_width_p = 32
  ,parameter sets_p = 16
  ,parameter block_words_p = 4
  ,localparam blk_w_lp = addr_width_p - $clog2(block_words_p)
) (
  input clock_i
  ,input reset_i

  ,input c_v_i
  ,output logic c_ready_o
  ,input cache_pkg::cache_op_e c_op_i
  ,input [addr_width_p-1:0] c_addr_i
  ,input [data_width_p-1:0] c_data_i

  ,output logic r_v_o
  ,input r_ready_i
  ,output logic [data_width_p-1:0] r_data_o

  ,output logic dma_v_o
  ,input dma_ready_i
  ,output dma_pkg::dma_op_e dma_op_o
  ,output logic [blk_w_lp-1:0] dma_addr_o

  ,output logic wd_v_o
  ,input wd_ready_i
  ,output logic [data_width_p-1:0] wd_data_o

  ,input rd_v_i
  ,output logic rd_ready_o
  ,input [data_width_p-1:0] rd_data_i
);

  import cache_pkg::*;
  import dma_pkg::*;

  localparam off_w_lp = $clog2(block_words_p);
  localparam idx_w_lp = $clog2(sets_p);
  localparam tag_w_lp = addr_width_p - off_w_lp - idx_w_lp;

  cache_state_e state_r;
  cache_op_e op_r;
  logic [addr_width_p-1:0] addr_r;
  logic [data_width_p-1:0] data_r;
  logic [data_width_p-1:0] r_data_r;
  logic [off_w_lp-1:0] cnt_r;

  logic [tag_w_lp-1:0] tag_mem [sets_p];
  logic [sets_p-1:0] valid_r;
  logic [sets_p-1:0] dirty_r;
  logic [data_width_p-1:0] data_mem [sets_p*block_words_p];

  logic [tag_w_lp-1:0] tag_s;
  logic [idx_w_lp-1:0] idx_s;
  logic [off_w_lp-1:0] off_s;
  logic hit;
  logic last_word;

  // address split of the request being served
  assign tag_s = addr_r[addr_width_p-1 -: tag_w_lp];
  assign idx_s = addr_r[off_w_lp +: idx_w_lp];
  assign off_s = addr_r[off_w_lp-1:0];
  assign hit = valid_r[idx_s] && (tag_mem[idx_s] == tag_s);
  assign last_word = (cnt_r == off_w_lp'(block_words_p - 1));

  assign c_ready_o = (state_r == cache_pkg::IDLE);
  assign r_v_o = (state_r == RESP);
  assign r_data_o = r_data_r;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // DMA side
  assign dma_v_o = (state_r == EVICT_REQ) || (state_r == FILL_REQ);
  assign dma_op_o = (state_r == EVICT_REQ) ? BLOCK_WRITE : BLOCK_READ;
  // victim block address comes from the stored tag
  assign dma_addr_o = (state_r == EVICT_REQ) ? {tag_mem[idx_s], idx_s} : {tag_s, idx_s};
  assign wd_v_o = (state_r == EVICT_DATA);
  assign wd_data_o = data_mem[{idx_s, cnt_r}];
  assign rd_ready_o = (state_r == FILL_DATA);

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // miss FSM
  always_ff @(posedge clock_i) begin
    if (reset_i) begin
      state_r <= cache_pkg::IDLE;
      valid_r <= '0;
      dirty_r <= '0;
      cnt_r <= '0;
    end else begin
      case (state_r)
        cache_pkg::IDLE: begin
          if (c_v_i) begin
            state_r <= LOOKUP;
          end
        end
        LOOKUP: begin
          if (hit) begin
            if (op_r == STORE) begin
              dirty_r[idx_s] <= 1'b1;
            end
            state_r <= RESP;
          end else begin
            cnt_r <= '0;
            state_r <= (valid_r[idx_s] && dirty_r[idx_s]) ? EVICT_REQ : FILL_REQ;
          end
        end
        EVICT_REQ: begin
          if (dma_ready_i) begin
            state_r <= EVICT_DATA;
          end
        end
        EVICT_DATA: begin
          if (wd_ready_i) begin
            cnt_r <= cnt_r + 1'b1;
            if (last_word) begin
              state_r <= FILL_REQ;
            end
          end
        end
        FILL_REQ: begin
          if (dma_ready_i) begin
            state_r <= FILL_DATA;
          end
        end
        FILL_DATA: begin
          if (rd_v_i) begin
            cnt_r <= cnt_r + 1'b1;
            if (last_word) begin
              valid_r[idx_s] <= 1'b1;
              dirty_r[idx_s] <= 1'b0;
              // replay the access on the new line
              state_r <= LOOKUP;
            end
          end
        end
        RESP: begin
          if (r_ready_i) begin
            state_r <= cache_pkg::IDLE;
          end
        end
        default: state_r <= cache_pkg::IDLE;
      endcase
    end
  end

  // request latch, tag and data arrays
  always_ff @(posedge clock_i) begin
    if (c_v_i && c_ready_o) begin
      op_r <= c_op_i;
      addr_r <= c_addr_i;
      data_r <= c_data_i;
    end
    if (state_r == LOOKUP && hit) begin
      if (op_r == STORE) begin
        data_mem[{idx_s, off_s}] <= data_r;
      end else begin
        r_data_r <= data_mem[{idx_s, off_s}];
      end
    end
    if (rd_v_i && rd_ready_o) begin
      data_mem[{idx_s, cnt_r}] <= rd_data_i;
      if (last_word) begin
        tag_mem[idx_s] <= tag_s;
      end
    end
  end

  // DMA traffic only for a miss and write-back only for a dirty line
  assert property (@(posedge clock_i) disable iff (reset_i)
    dma_v_o |-> !hit && (dma_op_o == BLOCK_READ || (valid_r[idx_s] && dirty_r[idx_s])))
    else $error("cache_dm: DMA request without a miss to serve");

  // response stays put until the link adapter takes it
  assert property (@(posedge clock_i) disable iff (reset_i)
    r_v_o && !r_ready_i |=> r_v_o && $stable(r_data_o))
    else $error("cache_dm: response dropped or changed under back-pressure");

endmodule

// File: design/cache_pkg.sv
/*
 * cache_pkg
 * Types for the network and cache side of the memory tile: the
 * request operation and the states of the direct-mapped cache FSM.
 */
package cache_pkg;

  // operation of a network request, one bit on the link
  typedef enum logic {
    LOAD  = 1'b0,
    STORE = 1'b1
  } cache_op_e;

  // miss handling walks evict, then fill, then replays the lookup
  typedef enum logic [2:0] {
    IDLE       = 3'd0,
    LOOKUP     = 3'd1,
    EVICT_REQ  = 3'd2,
    EVICT_DATA = 3'd3,
    FILL_REQ   = 3'd4,
    FILL_DATA  = 3'd5,
    RESP       = 3'd6
  } cache_state_e;

endpackage

// File: design/cache_tile_top.sv
/*
 * cache_tile_top
 * Memory tile: network link adapter, direct-mapped cache and the
 * cache-to-memory DMA adapter, chained in that order.
 */
module cache_tile_top #(
  parameter addr_width_p = 12
  ,parameter data_width_p = 32
  ,parameter sets_p = 16
  ,parameter block_words_p = 4
  ,parameter src_width_p = 4
) (
  input clock_i
  ,input reset_i

  ,input req_v_i
  ,output logic req_ready_o
  ,input cache_pkg::cache_op_e req_op_i
  ,input [addr_width_p-1:0] req_addr_i
  ,input [data_width_p-1:0] req_data_i
  ,input [src_width_p-1:0] req_src_i

  ,output logic ret_v_o
  ,input ret_ready_i
  ,output cache_pkg::cache_op_e ret_op_o
  ,output logic [data_width_p-1:0] ret_data_o
  ,output logic [src_width_p-1:0] ret_dst_o

  ,output logic mem_v_o
  ,input mem_ready_i
  ,output logic mem_we_o
  ,output logic [addr_width_p-1:0] mem_addr_o
  ,output logic [data_width_p-1:0] mem_wdata_o
  ,input mem_rdata_v_i
  ,input [data_width_p-1:0] mem_rdata_i
);

  import cache_pkg::*;
  import dma_pkg::*;

  localparam blk_w_lp = addr_width_p - $clog2(block_words_p);

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // link adapter to cache
  logic c_v, c_ready, r_v, r_ready;
  cache_op_e c_op;
  logic [addr_width_p-1:0] c_addr;
  logic [data_width_p-1:0] c_data, r_data;

  // cache to DMA adapter
  logic dma_v, dma_ready, wd_v, wd_ready, rd_v, rd_ready;
  dma_op_e dma_op;
  logic [blk_w_lp-1:0] dma_addr;
  logic [data_width_p-1:0] wd_data, rd_data;

  link_to_cache #(
    .addr_width_p(addr_width_p)
    ,.data_width_p(data_width_p)
    ,.src_width_p(src_width_p)
  ) link_to_cache_i (
    .clock_i(clock_i)
    ,.reset_i(reset_i)
    ,.req_v_i(req_v_i), .req_ready_o(req_ready_o), .req_op_i(req_op_i)
    ,.req_addr_i(req_addr_i), .req_data_i(req_data_i), .req_src_i(req_src_i)
    ,.ret_v_o(ret_v_o), .ret_ready_i(ret_ready_i), .ret_op_o(ret_op_o)
    ,.ret_data_o(ret_data_o), .ret_dst_o(ret_dst_o)
    ,.c_v_o(c_v), .c_ready_i(c_ready), .c_op_o(c_op)
    ,.c_addr_o(c_addr), .c_data_o(c_data)
    ,.r_v_i(r_v), .r_ready_o(r_ready), .r_data_i(r_data)
  );

  cache_dm #(
    .addr_width_p(addr_width_p)
    ,.data_width_p(data_width_p)
    ,.sets_p(sets_p)
    ,.block_words_p(block_words_p)
  ) cache_i (
    .clock_i(clock_i)
    ,.reset_i(reset_i)
    ,.c_v_i(c_v), .c_ready_o(c_ready), .c_op_i(c_op)
    ,.c_addr_i(c_addr), .c_data_i(c_data)
    ,.r_v_o(r_v), .r_ready_i(r_ready), .r_data_o(r_data)
    ,.dma_v_o(dma_v), .dma_ready_i(dma_ready), .dma_op_o(dma_op), .dma_addr_o(dma_addr)
    ,.wd_v_o(wd_v), .wd_ready_i(wd_ready), .wd_data_o(wd_data)
    ,.rd_v_i(rd_v), .rd_ready_o(rd_ready), .rd_data_i(rd_data)
  );

  cache_to_mem #(
    .addr_width_p(addr_width_p)
    ,.data_width_p(data_width_p)
    ,.block_words_p(block_words_p)
  ) cache_to_mem_i (
    .clock_i(clock_i)
    ,.reset_i(reset_i)
    ,.dma_v_i(dma_v), .dma_ready_o(dma_ready), .dma_op_i(dma_op), .dma_addr_i(dma_addr)
    ,.wd_v_i(wd_v), .wd_ready_o(wd_ready), .wd_data_i(wd_data)
    ,.rd_v_o(rd_v), .rd_ready_i(rd_ready), .rd_data_o(rd_data)
    ,.mem_v_o(mem_v_o), .mem_ready_i(mem_ready_i), .mem_we_o(mem_we_o)
    ,.mem_addr_o(mem_addr_o), .mem_wdata_o(mem_wdata_o)
    ,.mem_rdata_v_i(mem_rdata_v_i), .mem_rdata_i(mem_rdata_i)
  );

endmodule

// File: design/cache_to_mem.sv
/*
 * cache_to_mem
 * Turns block DMA reads and writes from the cache into single-word
 * transfers on the memory port, at most one read outstanding.
 */
module cache_to_mem #(
  parameter addr_width_p = 12
  ,parameter data_width_p = 32
  ,parameter block_words_p = 4
  ,localparam blk_w_lp = addr_width_p - $clog2(block_words_p)
) (
  input clock_i
  ,input reset_i

  ,input dma_v_i
  ,output logic dma_ready_o
  ,input dma_pkg::dma_op_e dma_op_i
  ,input [blk_w_lp-1:0] dma_addr_i

  ,input wd_v_i
  ,output logic wd_ready_o
  ,input [data_width_p-1:0] wd_data_i

  ,output logic rd_v_o
  ,input rd_ready_i
  ,output logic [data_width_p-1:0] rd_data_o

  ,output logic mem_v_o
  ,input mem_ready_i
  ,output logic mem_we_o
  ,output logic [addr_width_p-1:0] mem_addr_o
  ,output logic [data_width_p-1:0] mem_wdata_o
  ,input mem_rdata_v_i
  ,input [data_width_p-1:0] mem_rdata_i
);

  import dma_pkg::*;

  localparam off_w_lp = $clog2(block_words_p);

  dma_state_e state_r;
  logic [blk_w_lp-1:0] blk_r;
  logic [off_w_lp-1:0] cnt_r;
  logic [data_width_p-1:0] rd_data_r;
  logic rd_v_r;
  logic last_word;
  logic waiting;

  assign last_word = (cnt_r == off_w_lp'(block_words_p - 1));
  // read issued, data not yet back
  assign waiting = (state_r == READ_DATA) && !rd_v_r;

  assign dma_ready_o = (state_r == IDLE);
  assign wd_ready_o = (state_r == WRITE) && mem_ready_i;
  assign mem_v_o = (state_r == READ_REQ) || ((state_r == WRITE) && wd_v_i);
  assign mem_we_o = (state_r == WRITE);
  assign mem_addr_o = {blk_r, cnt_r};
  assign mem_wdata_o = wd_data_i;
  assign rd_v_o = rd_v_r;
  assign rd_data_o = rd_data_r;

  always_ff @(posedge clock_i) begin
    if (reset_i) begin
      state_r <= IDLE;
      cnt_r <= '0;
      rd_v_r <= 1'b0;
    end else begin
      case (state_r)
        IDLE: begin
          if (dma_v_i) begin
            cnt_r <= '0;
            state_r <= (dma_op_i == BLOCK_WRITE) ? WRITE : READ_REQ;
          end
        end
        WRITE: begin
          if (wd_v_i && mem_ready_i) begin
            cnt_r <= cnt_r + 1'b1;
            if (last_word) begin
              state_r <= IDLE;
            end
          end
        end
        READ_REQ: begin
          if (mem_ready_i) begin
            state_r <= READ_DATA;
          end
        end
        READ_DATA: begin
          if (waiting && mem_rdata_v_i) begin
            rd_v_r <= 1'b1;
          end
          if (rd_v_r && rd_ready_i) begin
            rd_v_r <= 1'b0;
            cnt_r <= cnt_r + 1'b1;
            state_r <= last_word ? IDLE : READ_REQ;
          end
        end
        default: state_r <= IDLE;
      endcase
    end
  end

  always_ff @(posedge clock_i) begin
    if (dma_v_i && dma_ready_o) begin
      blk_r <= dma_addr_i;
    end
    if (waiting && mem_rdata_v_i) begin
      rd_data_r <= mem_rdata_i;
    end
  end

  assert property (@(posedge clock_i) disable iff (reset_i) mem_rdata_v_i |-> waiting)
    else $error("cache_to_mem: memory read data with no read outstanding");

endmodule

// File: design/dma_pkg.sv
/*
 * dma_pkg
 * Block DMA operation and the states of the cache-to-memory adapter.
 */
package dma_pkg;

  typedef enum logic {
    BLOCK_READ  = 1'b0,
    BLOCK_WRITE = 1'b1
  } dma_op_e;

  // one word read in flight at a time
  typedef enum logic [1:0] {
    IDLE      = 2'd0,
    READ_REQ  = 2'd1,
    READ_DATA = 2'd2,
    WRITE     = 2'd3
  } dma_state_e;

endpackage

// File: design/link_to_cache.sv
/*
 * link_to_cache
 * Network link adapter of the memory tile. Passes requests straight
 * through to the cache and remembers source id and op of each one in
 * a two-entry queue, so return packets go back to the right sender.
 */
module link_to_cache #(
  parameter addr_width_p = 12
  ,parameter data_width_p = 32
  ,parameter src_width_p = 4
) (
  input clock_i
  ,input reset_i

  ,input req_v_i
  ,output logic req_ready_o
  ,input cache_pkg::cache_op_e req_op_i
  ,input [addr_width_p-1:0] req_addr_i
  ,input [data_width_p-1:0] req_data_i
  ,input [src_width_p-1:0] req_src_i

  ,output logic ret_v_o
  ,input ret_ready_i
  ,output cache_pkg::cache_op_e ret_op_o
  ,output logic [data_width_p-1:0] ret_data_o
  ,output logic [src_width_p-1:0] ret_dst_o

  ,output logic c_v_o
  ,input c_ready_i
  ,output cache_pkg::cache_op_e c_op_o
  ,output logic [addr_width_p-1:0] c_addr_o
  ,output logic [data_width_p-1:0] c_data_o

  ,input r_v_i
  ,output logic r_ready_o
  ,input [data_width_p-1:0] r_data_i
);

  import cache_pkg::*;

  localparam depth_lp = 2;

  logic [src_width_p-1:0] src_q [depth_lp];
  cache_op_e op_q [depth_lp];
  logic wr_ptr_r;
  logic rd_ptr_r;
  logic [1:0] count_r;
  logic up_r;
  logic has_space;
  logic push;
  logic pop;

  // request side
  assign has_space = (count_r != 2'(depth_lp));
  assign c_v_o = req_v_i & has_space & up_r;
  assign req_ready_o = c_ready_i & has_space & up_r;
  assign c_op_o = req_op_i;
  assign c_addr_o = req_addr_i;
  assign c_data_o = req_data_i;
  assign push = req_v_i & req_ready_o;

  // return side, head of queue names the destination
  assign ret_v_o = r_v_i & (count_r != 2'd0);
  assign r_ready_o = ret_ready_i;
  assign ret_op_o = op_q[rd_ptr_r];
  assign ret_dst_o = src_q[rd_ptr_r];
  assign ret_data_o = (op_q[rd_ptr_r] == STORE) ? '0 : r_data_i;
  assign pop = ret_v_o & ret_ready_i;

  always_ff @(posedge clock_i) begin
    if (reset_i) begin
      up_r <= 1'b0;
      wr_ptr_r <= 1'b0;
      rd_ptr_r <= 1'b0;
      count_r <= 2'd0;
    end else begin
      up_r <= 1'b1;
      if (push) begin
        wr_ptr_r <= ~wr_ptr_r;
      end
      if (pop) begin
        rd_ptr_r <= ~rd_ptr_r;
      end
      if (push && !pop) begin
        count_r <= count_r + 2'd1;
      end else if (pop && !push) begin
        count_r <= count_r - 2'd1;
      end
    end
  end

  always_ff @(posedge clock_i) begin
    if (push) begin
      src_q[wr_ptr_r] <= req_src_i;
      op_q[wr_ptr_r] <= req_op_i;
    end
  end

  // every cache response must belong to a request pushed here earlier
  assert property (@(posedge clock_i) disable iff (reset_i) r_v_i |-> count_r != 2'd0)
    else $error("link_to_cache: cache response with no source queued");

endmodule

// File: verif/mem_model.sv
/*
 * mem_model
 * External word memory behind the tile's memory port. Filled with an
 * address pattern, accepts requests on a random ready, counts writes
 * per address and returns read data in order 1 to 4 cycles later.
 */
module mem_model #(
  parameter addr_width_p = 12
  ,parameter data_width_p = 32
  ,parameter logic [31:0] pat_mul_p = 32'h0000_0101
  ,parameter logic [31:0] pat_xor_p = 32'h5A5A_0000
  ,parameter integer seed_p = 49
) (
  input clock_i
  ,input reset_i

  ,input mem_v_i
  ,output logic mem_ready_o
  ,input mem_we_i
  ,input [addr_width_p-1:0] mem_addr_i
  ,input [data_width_p-1:0] mem_wdata_i
  ,output logic mem_rdata_v_o
  ,output logic [data_width_p-1:0] mem_rdata_o
);

  localparam words_lp = 2**addr_width_p;

  logic [data_width_p-1:0] mem [words_lp];
  int wr_count [words_lp];
  logic [data_width_p-1:0] rdata_q [$];
  int due_q [$];
  int cycle;
  int due;
  int a;
  integer seed;
  integer rnd;

  initial begin
    seed = seed_p;
    cycle = 0;
    mem_ready_o = 1'b0;
    mem_rdata_v_o = 1'b0;
    mem_rdata_o = '0;
    for (a = 0; a < words_lp; a++) begin
      mem[a] = (32'(a) * pat_mul_p) ^ pat_xor_p;
      wr_count[a] = 0;
    end
    forever begin
      @(posedge clock_i);
      cycle++;
      if (reset_i) begin
        mem_ready_o <= 1'b0;
        mem_rdata_v_o <= 1'b0;
        rdata_q.delete();
        due_q.delete();
      end else begin
        // request seen with the ready that was up before this edge
        if (mem_v_i && mem_ready_o) begin
          if (mem_we_i) begin
            mem[mem_addr_i] = mem_wdata_i;
            wr_count[mem_addr_i]++;
          end else begin
            rnd = $random(seed);
            due = cycle + 1 + int'(rnd[1:0]);
            // never overtake an older read
            if (due_q.size() > 0 && due < due_q[$]) begin
              due = due_q[$];
            end
            rdata_q.push_back(mem[mem_addr_i]);
            due_q.push_back(due);
          end
        end
        rnd = $random(seed);
        mem_ready_o <= (rnd[1:0] != 2'b00);
        if (due_q.size() > 0 && due_q[0] <= cycle) begin
          mem_rdata_v_o <= 1'b1;
          mem_rdata_o <= rdata_q.pop_front();
          due = due_q.pop_front();
        end else begin
          mem_rdata_v_o <= 1'b0;
        end
      end
    end
  end

endmodule

// File: verif/tb_cache_tile.sv
/*
 * tb_cache_tile
 * Testbench for the memory tile. Plays the network side from a table of
 * requests with expected returns, and the external memory through
 * mem_model. Returns are checked in request order.
 */
module tb_cache_tile;

  import cache_pkg::*;

  localparam addr_width_lp = 12;
  localparam data_width_lp = 32;
  localparam sets_lp = 16;
  localparam block_words_lp = 4;
  localparam src_width_lp = 4;
  localparam half_period_lp = 20;
  localparam wait_limit_lp = 2000;
  localparam random_count_lp = 12;
  localparam logic [31:0] pat_mul_lp = 32'h0000_0101;
  localparam logic [31:0] pat_xor_lp = 32'h5A5A_0000;

  logic clock_i;
  logic reset_i;
  logic req_v_i;
  logic req_ready_o;
  cache_op_e req_op_i;
  logic [addr_width_lp-1:0] req_addr_i;
  logic [data_width_lp-1:0] req_data_i;
  logic [src_width_lp-1:0] req_src_i;
  logic ret_v_o;
  logic ret_ready_i;
  cache_op_e ret_op_o;
  logic [data_width_lp-1:0] ret_data_o;
  logic [src_width_lp-1:0] ret_dst_o;
  logic mem_v_o;
  logic mem_ready_i;
  logic mem_we_o;
  logic [addr_width_lp-1:0] mem_addr_o;
  logic [data_width_lp-1:0] mem_wdata_o;
  logic mem_rdata_v_i;
  logic [data_width_lp-1:0] mem_rdata_i;

  // stimulus table, one row per request
  cache_op_e tbl_op [$];
  logic [addr_width_lp-1:0] tbl_addr [$];
  logic [data_width_lp-1:0] tbl_data [$];
  logic [src_width_lp-1:0] tbl_src [$];
  logic [data_width_lp-1:0] tbl_exp [$];
  bit tbl_hit [$];
  logic [data_width_lp-1:0] ref_mem [int];

  int pend_q [$];
  time acc_q [$];
  int rand_from;
  integer seed;
  int checks;
  int mismatches;
  int timeouts;
  int others;
  bit abort_run;
  bit run_done;
  bit rand_ret;

  cache_tile_top #(
    .addr_width_p(addr_width_lp)
    ,.data_width_p(data_width_lp)
    ,.sets_p(sets_lp)
    ,.block_words_p(block_words_lp)
    ,.src_width_p(src_width_lp)
  ) dut_i (
    .clock_i(clock_i)
    ,.reset_i(reset_i)
    ,.req_v_i(req_v_i), .req_ready_o(req_ready_o), .req_op_i(req_op_i)
    ,.req_addr_i(req_addr_i), .req_data_i(req_data_i), .req_src_i(req_src_i)
    ,.ret_v_o(ret_v_o), .ret_ready_i(ret_ready_i), .ret_op_o(ret_op_o)
    ,.ret_data_o(ret_data_o), .ret_dst_o(ret_dst_o)
    ,.mem_v_o(mem_v_o), .mem_ready_i(mem_ready_i), .mem_we_o(mem_we_o)
    ,.mem_addr_o(mem_addr_o), .mem_wdata_o(mem_wdata_o)
    ,.mem_rdata_v_i(mem_rdata_v_i), .mem_rdata_i(mem_rdata_i)
  );

  mem_model #(
    .addr_width_p(addr_width_lp)
    ,.data_width_p(data_width_lp)
    ,.pat_mul_p(pat_mul_lp)
    ,.pat_xor_p(pat_xor_lp)
    ,.seed_p(49)
  ) mem_i (
    .clock_i(clock_i)
    ,.reset_i(reset_i)
    ,.mem_v_i(mem_v_o), .mem_ready_o(mem_ready_i), .mem_we_i(mem_we_o)
    ,.mem_addr_i(mem_addr_o), .mem_wdata_i(mem_wdata_o)
    ,.mem_rdata_v_o(mem_rdata_v_i), .mem_rdata_o(mem_rdata_i)
  );

  initial begin
    clock_i = 1'b0;
    forever #half_period_lp clock_i = ~clock_i;
  end

  function automatic logic [31:0] pattern_word(input logic [addr_width_lp-1:0] addr);
    return (32'(addr) * pat_mul_lp) ^ pat_xor_lp;
  endfunction

  // expected return follows the reference memory in issue order
  task add_entry(input cache_op_e op, input logic [addr_width_lp-1:0] addr,
                 input logic [31:0] data, input logic [src_width_lp-1:0] src, input bit hit);
    logic [31:0] exp;
    if (op == STORE) begin
      ref_mem[int'(addr)] = data;
      exp = '0;
    end else if (ref_mem.exists(int'(addr))) begin
      exp = ref_mem[int'(addr)];
    end else begin
      exp = pattern_word(addr);
    end
    tbl_op.push_back(op);
    tbl_addr.push_back(addr);
    tbl_data.push_back(data);
    tbl_src.push_back(src);
    tbl_exp.push_back(exp);
    tbl_hit.push_back(hit);
  endtask

  task build_table;
    logic [31:0] rnd;
    logic [31:0] data;
    logic [addr_width_lp-1:0] a;
    int k;
    // untouched block in set 8, then a hit in the same block
    add_entry(LOAD, 12'h123, 32'h0, 4'h1, 1'b0);
    add_entry(LOAD, 12'h121, 32'h0, 4'h2, 1'b1);
    add_entry(STORE, 12'h2A5, 32'hCAFE_0001, 4'h3, 1'b0);
    add_entry(LOAD, 12'h2A5, 32'h0, 4'h4, 1'b1);
    // dirty line in set 5, conflicting tag evicts it, then reload
    add_entry(STORE, 12'h314, 32'hDEAD_0314, 4'h5, 1'b0);
    add_entry(LOAD, 12'h714, 32'h0, 4'h6, 1'b0);
    add_entry(LOAD, 12'h314, 32'h0, 4'h7, 1'b0);
    rand_from = tbl_op.size();
    for (k = 0; k < random_count_lp; k++) begin
      rnd = $random(seed);
      data = $random(seed);
      a = {rnd[11] ? 6'h20 : 6'h10, rnd[5:0]};
      add_entry(rnd[12] ? STORE : LOAD, a, data, rnd[19:16], 1'b0);
    end
  endtask

  task wait_reset_clear;
    int n;
    n = 0;
    do begin
      @(negedge clock_i);
      n++;
    end while (!req_ready_o && n < wait_limit_lp);
    if (!req_ready_o) begin
      $display("req_ready_o never came up after reset");
      timeouts++;
      abort_run = 1'b1;
    end
  endtask

  task check_idle(input int cycles);
    repeat (cycles) begin
      @(negedge clock_i);
      checks++;
      if (ret_v_o !== 1'b0) begin
        $display("** Error ret_v_o before first request: got %h, expected 0", ret_v_o);
        mismatches++;
      end
      if (mem_v_o !== 1'b0) begin
        $display("** Error mem_v_o before first request: got %h, expected 0", mem_v_o);
        mismatches++;
      end
    end
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // request side, back to back
  task drive_requests;
    int idx;
    int n;
    @(posedge clock_i);
    for (idx = 0; idx < tbl_op.size() && !abort_run; idx++) begin
      if (idx == rand_from) begin
        rand_ret <= 1'b1;
      end
      req_v_i <= 1'b1;
      req_op_i <= tbl_op[idx];
      req_addr_i <= tbl_addr[idx];
      req_data_i <= tbl_data[idx];
      req_src_i <= tbl_src[idx];
      n = 0;
      do begin
        @(negedge clock_i);
        n++;
      end while (!req_ready_o && n < wait_limit_lp && !abort_run);
      if (!req_ready_o) begin
        if (!abort_run) begin
          $display("request %0d was never accepted", idx);
          timeouts++;
          abort_run = 1'b1;
        end
      end else begin
        // transfer edge
        @(posedge clock_i);
        pend_q.push_back(idx);
        acc_q.push_back($time);
      end
    end
    req_v_i <= 1'b0;
  endtask

  task compare_return(input int idx, input int lat);
    checks++;
    if (ret_data_o !== tbl_exp[idx]) begin
      $display("** Error ret_data_o entry %0d: got %h, expected %h", idx, ret_data_o,
               tbl_exp[idx]);
      mismatches++;
    end
    if (ret_dst_o !== tbl_src[idx]) begin
      $display("** Error ret_dst_o entry %0d: got %h, expected %h", idx, ret_dst_o,
               tbl_src[idx]);
      mismatches++;
    end
    if (ret_op_o !== tbl_op[idx]) begin
      $display("** Error ret_op_o entry %0d: got %h, expected %h", idx, ret_op_o, tbl_op[idx]);
      mismatches++;
    end
    if (tbl_hit[idx] && lat != 2) begin
      $display("hit on entry %0d returned %0d cycles after acceptance instead of 2", idx, lat);
      others++;
    end
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // return side, in request order
  task check_returns;
    int k;
    int n;
    int idx;
    int lat;
    time t_seen;
    time t_acc;
    for (k = 0; k < tbl_op.size() && !abort_run; k++) begin
      n = 0;
      t_seen = 0;
      do begin
        @(negedge clock_i);
        n++;
        if (ret_v_o && t_seen == 0) begin
          t_seen = $time;
        end
      end while (!(ret_v_o && ret_ready_i) && n < wait_limit_lp && !abort_run);
      if (!(ret_v_o && ret_ready_i)) begin
        if (!abort_run) begin
          $display("no return packet for entry %0d within %0d cycles", k, wait_limit_lp);
          timeouts++;
          abort_run = 1'b1;
        end
      end else if (pend_q.size() == 0) begin
        $display("return packet arrived with no request outstanding");
        others++;
      end else begin
        idx = pend_q.pop_front();
        t_acc = acc_q.pop_front();
        lat = int'((t_seen + half_period_lp - t_acc) / (2 * half_period_lp));
        compare_return(idx, lat);
      end
    end
    run_done = 1'b1;
  endtask

  task drive_ret_ready;
    integer rnd;
    while (!run_done) begin
      @(posedge clock_i);
      rnd = $random(seed);
      ret_ready_i <= rand_ret ? rnd[0] : 1'b1;
    end
  endtask

  // the evicted block went back to memory exactly once
  task check_writeback;
    checks++;
    if (mem_i.wr_count[12'h314] != 1) begin
      $display("** Error mem_i.wr_count[314]: got %h, expected %h", mem_i.wr_count[12'h314], 1);
      mismatches++;
    end
    if (mem_i.mem[12'h314] !== 32'hDEAD_0314) begin
      $display("** Error mem_i.mem[314]: got %h, expected %h", mem_i.mem[12'h314],
               32'hDEAD_0314);
      mismatches++;
    end
    if (mem_i.mem[12'h315] !== pattern_word(12'h315)) begin
      $display("** Error mem_i.mem[315]: got %h, expected %h", mem_i.mem[12'h315],
               pattern_word(12'h315));
      mismatches++;
    end
  endtask

  initial begin
    reset_i = 1'b1;
    req_v_i = 1'b0;
    req_op_i = LOAD;
    req_addr_i = '0;
    req_data_i = '0;
    req_src_i = '0;
    ret_ready_i = 1'b0;
    seed = 49;
    checks = 0;
    mismatches = 0;
    timeouts = 0;
    others = 0;
    abort_run = 1'b0;
    run_done = 1'b0;
    rand_ret = 1'b0;
    build_table();
    repeat (16) @(posedge clock_i);
    reset_i <= 1'b0;
    wait_reset_clear();
    if (!abort_run) begin
      check_idle(8);
      fork
        drive_requests();
        check_returns();
        drive_ret_ready();
      join
    end
    if (!abort_run) begin
      check_writeback();
    end
    $display("checks %0d, mismatches %0d, timeouts %0d, other errors %0d",
             checks, mismatches, timeouts, others);
    if (mismatches + timeouts + others == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule
